// File: hdl/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// dispatch queue depth, also the dispatcher's starting credit
`define MEM_IQ_DEPTH 4

// store buffer slots, also the agu's starting store credit
`define MEM_STB_ENTRIES 4

// data memory size in 32-bit words
`define MEM_WORDS 256

`endif

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // funct3 codes, stores reuse B/H/W
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_BU = 3'b100,
        LS_HU = 3'b101
    } ls_type_e;

    typedef enum logic [2:0] {
        EXC_LD_MISALIGN = 3'd4,
        EXC_ST_MISALIGN = 3'd6
    } exc_code_e;

    typedef struct packed {
        logic        is_store;
        ls_type_e    ls_type;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] data;   // store data, unused for loads
        logic [4:0]  rob;
        logic [5:0]  dest;
    } mem_op_t;

    typedef struct packed {
        logic [29:0] waddr;
        logic [31:0] data;   // already on its byte lanes
        logic [3:0]  mask;
        logic [4:0]  rob;
    } st_req_t;

    typedef struct packed {
        logic [29:0] waddr;
        logic [1:0]  offset;
        ls_type_e    ls_type;
        logic [5:0]  dest;
        logic [4:0]  rob;
    } ld_req_t;

    typedef struct packed {
        logic [3:0]  hit;
        logic [31:0] data;
    } fwd_t;

    typedef struct packed {
        logic [5:0]  dest;
        logic [31:0] data;
    } wb_t;

    typedef struct packed {
        logic [4:0]  rob;
        exc_code_e   code;
        logic [31:0] addr;
    } exc_t;

endpackage

`default_nettype wire

// File: hdl/credit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
    parameter type PAYLOAD_T = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  wire logic     cpu_clk_i,
    input  wire logic     rst_n_i,
    input  wire logic     push_i,
    input  wire PAYLOAD_T data_i,
    input  wire logic     pop_i,
    output PAYLOAD_T      data_o,
    output logic          valid_o,
    output logic          credit_o
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    PAYLOAD_T      mem [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          do_pop;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign do_pop  = pop_i && valid_o;
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];

    // no full check, the sender only pushes with a credit in hand
    always_ff @(posedge cpu_clk_i) begin
        if (push_i)
            mem[wr_ptr] <= data_i;
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_o <= 1'b0;
        end else begin
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            count    <= count + CW'(push_i) - CW'(do_pop);
            credit_o <= do_pop;  // one credit back per pop
        end
    end

endmodule

`default_nettype wire

// File: hdl/agu.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module agu (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire mem_pkg::mem_op_t op_i,
    input  wire logic             op_valid_i,
    output logic                  take_o,
    output mem_pkg::st_req_t      st_req_o,
    output logic                  st_valid_o,
    input  wire logic             st_credit_i,
    output mem_pkg::ld_req_t      ld_req_o,
    output logic                  ld_valid_o,
    output mem_pkg::exc_t         exc_o,
    output logic                  exc_valid_o
);
    localparam int CW = $clog2(`MEM_STB_ENTRIES + 1);

    logic [31:0]   addr;
    logic          misaligned;
    logic [3:0]    mask;
    logic [CW-1:0] st_credits;
    logic          st_go;
    logic          ld_go;

    assign addr = op_i.base + op_i.imm;

    // size lives in the low two funct3 bits
    always_comb begin
        misaligned = 1'b0;
        mask       = 4'b1111;
        case (op_i.ls_type[1:0])
            2'b00: mask = 4'b0001 << addr[1:0];
            2'b01: begin
                misaligned = addr[0];
                mask       = 4'b0011 << addr[1:0];
            end
            default: misaligned = (addr[1:0] != 2'b00);
        endcase
    end

    // a misaligned op only raises an exception, so it never waits
    assign take_o = op_valid_i && (!op_i.is_store || misaligned || st_credits != '0);
    assign st_go  = take_o && op_i.is_store && !misaligned;
    assign ld_go  = take_o && !op_i.is_store && !misaligned;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            st_credits  <= CW'(`MEM_STB_ENTRIES);
            st_valid_o  <= 1'b0;
            ld_valid_o  <= 1'b0;
            exc_valid_o <= 1'b0;
        end else begin
            st_credits  <= st_credits - CW'(st_go) + CW'(st_credit_i);
            st_valid_o  <= st_go;
            ld_valid_o  <= ld_go;
            exc_valid_o <= take_o && misaligned;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        st_req_o.waddr   <= addr[31:2];
        st_req_o.data    <= op_i.data << {addr[1:0], 3'b000};  // onto byte lanes
        st_req_o.mask    <= mask;
        st_req_o.rob     <= op_i.rob;
        ld_req_o.waddr   <= addr[31:2];
        ld_req_o.offset  <= addr[1:0];
        ld_req_o.ls_type <= op_i.ls_type;
        ld_req_o.dest    <= op_i.dest;
        ld_req_o.rob     <= op_i.rob;
        exc_o.rob        <= op_i.rob;
        exc_o.code       <= op_i.is_store ? mem_pkg::EXC_ST_MISALIGN : mem_pkg::EXC_LD_MISALIGN;
        exc_o.addr       <= addr;
    end

endmodule

`default_nettype wire

// File: hdl/stb_entry.sv
`timescale 1ns/1ps
`default_nettype none

module stb_entry (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             alloc_i,
    input  wire mem_pkg::st_req_t req_i,
    input  wire logic             commit_i,
    input  wire logic             release_i,
    input  wire logic [29:0]      qaddr_i,
    output logic                  valid_o,
    output logic                  committed_o,
    output mem_pkg::st_req_t      req_o,
    output logic [3:0]            hit_mask_o
);

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            valid_o     <= 1'b0;
            committed_o <= 1'b0;
        end else begin
            if (alloc_i) begin
                valid_o     <= 1'b1;
                committed_o <= 1'b0;
            end else if (release_i) begin
                valid_o     <= 1'b0;
                committed_o <= 1'b0;
            end else if (commit_i) begin
                committed_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (alloc_i)
            req_o <= req_i;
    end

    // lanes this store would supply to a load of qaddr
    always_comb begin
        hit_mask_o = 4'b0000;
        if (valid_o && req_o.waddr == qaddr_i)
            hit_mask_o = req_o.mask;
    end

endmodule

`default_nettype wire

// File: hdl/store_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module store_buffer (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             st_valid_i,
    input  wire mem_pkg::st_req_t st_req_i,
    input  wire logic             commit_i,
    input  wire logic [29:0]      qaddr_i,
    output mem_pkg::fwd_t         fwd_o,
    output logic                  drain_valid_o,
    output mem_pkg::st_req_t      drain_o,
    output logic                  credit_o,
    output logic                  complete_o,
    output logic [4:0]            complete_rob_o,
    output logic                  empty_o
);
    localparam int N  = `MEM_STB_ENTRIES;
    localparam int PW = (N > 1) ? $clog2(N) : 1;

    logic [PW-1:0]    tail;
    logic [PW-1:0]    cmt;
    logic [PW-1:0]    head;
    logic [N-1:0]     ent_valid;
    logic [N-1:0]     ent_cmt;
    mem_pkg::st_req_t ent_req [N];
    logic [3:0]       ent_hit [N];

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
        return (p == PW'(N - 1)) ? '0 : p + 1'b1;
    endfunction

    for (genvar g = 0; g < N; g++) begin : g_ent
        stb_entry u_ent (
            .cpu_clk_i   (cpu_clk_i),
            .rst_n_i     (rst_n_i),
            .alloc_i     (st_valid_i && tail == PW'(g)),
            .req_i       (st_req_i),
            .commit_i    (commit_i && cmt == PW'(g)),
            .release_i   (drain_valid_o && head == PW'(g)),
            .qaddr_i     (qaddr_i),
            .valid_o     (ent_valid[g]),
            .committed_o (ent_cmt[g]),
            .req_o       (ent_req[g]),
            .hit_mask_o  (ent_hit[g])
        );
    end

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            tail <= '0;
            cmt  <= '0;
            head <= '0;
        end else begin
            if (st_valid_i)
                tail <= next_ptr(tail);
            if (commit_i)
                cmt <= next_ptr(cmt);
            if (drain_valid_o)
                head <= next_ptr(head);
        end
    end

    assign drain_valid_o  = ent_valid[head] && ent_cmt[head];
    assign drain_o        = ent_req[head];
    assign credit_o       = drain_valid_o;  // slot frees at this edge
    assign complete_o     = st_valid_i;
    assign complete_rob_o = st_req_i.rob;
    assign empty_o        = ~|ent_valid;

    // walk oldest to youngest so the youngest hit wins per byte
    always_comb begin
        int unsigned idx;
        fwd_o.hit  = 4'b0000;
        fwd_o.data = '0;
        for (int i = 0; i < N; i++) begin
            idx = (int'(head) + i) % N;
            for (int b = 0; b < 4; b++) begin
                if (ent_hit[idx][b]) begin
                    fwd_o.hit[b]          = 1'b1;
                    fwd_o.data[8*b +: 8]  = ent_req[idx].data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/load_unit.sv
`timescale 1ns/1ps
`default_nettype none

module load_unit (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire mem_pkg::ld_req_t ld_req_i,
    input  wire logic             ld_valid_i,
    output logic [29:0]           qaddr_o,
    input  wire mem_pkg::fwd_t    fwd_i,
    output logic [29:0]           rd_addr_o,
    input  wire logic [31:0]      rd_data_i,
    output logic                  wb_valid_o,
    output mem_pkg::wb_t          wb_o,
    output logic [4:0]            wb_rob_o
);
    mem_pkg::ld_req_t req_q;
    mem_pkg::fwd_t    fwd_q;
    logic [31:0]      merged;
    logic [31:0]      shifted;
    logic [31:0]      ext;

    // forward query and memory read go out together
    assign qaddr_o   = ld_req_i.waddr;
    assign rd_addr_o = ld_req_i.waddr;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i)
            wb_valid_o <= 1'b0;
        else
            wb_valid_o <= ld_valid_i;
    end

    always_ff @(posedge cpu_clk_i) begin
        req_q <= ld_req_i;
        fwd_q <= fwd_i;  // lines up with the registered read data
    end

    always_comb begin
        for (int b = 0; b < 4; b++)
            merged[8*b +: 8] = fwd_q.hit[b] ? fwd_q.data[8*b +: 8] : rd_data_i[8*b +: 8];
        shifted = merged >> {req_q.offset, 3'b000};
        case (req_q.ls_type)
            mem_pkg::LS_B:  ext = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::LS_BU: ext = {24'h0, shifted[7:0]};
            mem_pkg::LS_H:  ext = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::LS_HU: ext = {16'h0, shifted[15:0]};
            default:        ext = shifted;
        endcase
    end

    assign wb_o.dest = req_q.dest;
    assign wb_o.data = ext;
    assign wb_rob_o  = req_q.rob;

endmodule

`default_nettype wire

// File: hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module data_mem (
    input  wire logic             cpu_clk_i,
    input  wire logic             we_i,
    input  wire mem_pkg::st_req_t wr_i,
    input  wire logic [29:0]      rd_addr_i,
    output logic [31:0]           rd_data_o
);
    localparam int AW = $clog2(`MEM_WORDS);

    logic [31:0]   mem [`MEM_WORDS];
    logic [AW-1:0] wa;
    logic [AW-1:0] ra;
    logic [31:0]   wr_word;

    assign wa = wr_i.waddr[AW-1:0];
    assign ra = rd_addr_i[AW-1:0];

    // current word with the masked lanes replaced
    always_comb begin
        wr_word = mem[wa];
        for (int b = 0; b < 4; b++)
            if (wr_i.mask[b])
                wr_word[8*b +: 8] = wr_i.data[8*b +: 8];
    end

    always_ff @(posedge cpu_clk_i) begin
        if (we_i)
            mem[wa] <= wr_word;
        if (we_i && wa == ra)
            rd_data_o <= wr_word;  // same-cycle drain seen by the load
        else
            rd_data_o <= mem[ra];
    end

endmodule

`default_nettype wire

// File: hdl/mem_system.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module mem_system (
    input  wire logic             cpu_clk_i,
    input  wire logic             rst_n_i,
    input  wire logic             op_valid_i,
    input  wire mem_pkg::mem_op_t op_i,
    output logic                  op_credit_o,
    input  wire logic             commit_i,
    output logic                  complete_o,
    output logic [4:0]            complete_rob_o,
    output logic                  wb_valid_o,
    output mem_pkg::wb_t          wb_o,
    output logic [4:0]            wb_rob_o,
    output logic                  exc_valid_o,
    output mem_pkg::exc_t         exc_o,
    output logic                  stb_empty_o
);
    mem_pkg::mem_op_t head_op;
    logic             head_valid;
    logic             take;
    mem_pkg::st_req_t st_req;
    logic             st_valid;
    logic             st_credit;
    mem_pkg::ld_req_t ld_req;
    logic             ld_valid;
    logic [29:0]      qaddr;
    mem_pkg::fwd_t    fwd;
    logic [29:0]      rd_addr;
    logic [31:0]      rd_data;
    logic             drain_valid;
    mem_pkg::st_req_t drain;

    credit_fifo #(
        .PAYLOAD_T (mem_pkg::mem_op_t),
        .DEPTH     (`MEM_IQ_DEPTH)
    ) u_iq (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .push_i    (op_valid_i),
        .data_i    (op_i),
        .pop_i     (take),
        .data_o    (head_op),
        .valid_o   (head_valid),
        .credit_o  (op_credit_o)
    );

    agu u_agu (
        .cpu_clk_i   (cpu_clk_i),
        .rst_n_i     (rst_n_i),
        .op_i        (head_op),
        .op_valid_i  (head_valid),
        .take_o      (take),
        .st_req_o    (st_req),
        .st_valid_o  (st_valid),
        .st_credit_i (st_credit),
        .ld_req_o    (ld_req),
        .ld_valid_o  (ld_valid),
        .exc_o       (exc_o),
        .exc_valid_o (exc_valid_o)
    );

    store_buffer u_stb (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .st_valid_i     (st_valid),
        .st_req_i       (st_req),
        .commit_i       (commit_i),
        .qaddr_i        (qaddr),
        .fwd_o          (fwd),
        .drain_valid_o  (drain_valid),
        .drain_o        (drain),
        .credit_o       (st_credit),
        .complete_o     (complete_o),
        .complete_rob_o (complete_rob_o),
        .empty_o        (stb_empty_o)
    );

    load_unit u_lu (
        .cpu_clk_i  (cpu_clk_i),
        .rst_n_i    (rst_n_i),
        .ld_req_i   (ld_req),
        .ld_valid_i (ld_valid),
        .qaddr_o    (qaddr),
        .fwd_i      (fwd),
        .rd_addr_o  (rd_addr),
        .rd_data_i  (rd_data),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o),
        .wb_rob_o   (wb_rob_o)
    );

    data_mem u_dmem (
        .cpu_clk_i (cpu_clk_i),
        .we_i      (drain_valid),
        .wr_i      (drain),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

endmodule

`default_nettype wire

// File: tb/mem_properties.sv
`timescale 1ns/1ps
`default_nettype none

module mem_properties (
    input  wire logic          cpu_clk_i,
    input  wire logic          rst_n_i,
    input  wire logic          commit_i,
    input  wire logic          drain_valid_i,
    input  wire logic          st_valid_i,
    input  wire logic          credit_i,
    input  wire logic          wb_valid_i,
    input  wire logic [4:0]    wb_rob_i,
    input  wire logic          exc_valid_i,
    input  wire mem_pkg::exc_t exc_i
);
    int unsigned cmt_ahead;  // commits not yet drained
    int unsigned held;       // stores sitting in the buffer
    logic        exc_q;
    logic [4:0]  exc_rob_q;

    always_ff @(posedge cpu_clk_i) begin
        if (!rst_n_i) begin
            cmt_ahead <= 0;
            held      <= 0;
            exc_q     <= 1'b0;
            exc_rob_q <= '0;
        end else begin
            cmt_ahead <= cmt_ahead + 32'(commit_i) - 32'(drain_valid_i);
            held      <= held + 32'(st_valid_i) - 32'(credit_i);
            exc_q     <= exc_valid_i;
            exc_rob_q <= exc_i.rob;
        end
    end

    a_drain_committed: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        drain_valid_i |-> cmt_ahead != 0)
        else $error("store buffer drained a head that was never committed");

    a_credit_not_empty: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        credit_i |-> held != 0)
        else $error("store credit returned while the buffer was empty");

    // a load's writeback trails its agu slot by one cycle
    a_wb_exc_exclusive: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        wb_valid_i |-> !(exc_valid_i && exc_i.rob == wb_rob_i) &&
                       !(exc_q && exc_rob_q == wb_rob_i))
        else $error("writeback and exception for the same rob");

endmodule

`default_nettype wire

// File: tb/tb_mem_system.sv
`timescale 1ns/1ps
`default_nettype none
`include "mem_config.svh"

module tb_mem_system;
    localparam int INIT_WORDS  = 16;
    localparam int N_RANDOM    = 200;
    localparam int N_DIRECTED  = 40;
    // about fifteen cycles per op covers stalls and the final drain
    localparam int CYCLE_LIMIT = 15 * (INIT_WORDS + N_RANDOM + N_DIRECTED) + 200;
    localparam int MEM_BYTES   = `MEM_WORDS * 4;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  size;
    } pend_st_t;

    typedef struct packed {
        mem_pkg::wb_t wb;
        logic [4:0]   rob;
    } exp_ld_t;

    logic             cpu_clk_i;
    logic             rst_n_i;
    logic             op_valid_i;
    mem_pkg::mem_op_t op_i;
    logic             op_credit_o;
    logic             commit_i;
    logic             complete_o;
    logic [4:0]       complete_rob_o;
    logic             wb_valid_o;
    mem_pkg::wb_t     wb_o;
    logic [4:0]       wb_rob_o;
    logic             exc_valid_o;
    mem_pkg::exc_t    exc_o;
    logic             stb_empty_o;

    logic [7:0]    ref_mem [MEM_BYTES];
    pend_st_t      pend_st [$];  // dispatched stores not yet committed, oldest first
    exp_ld_t       exp_wb [$];
    mem_pkg::exc_t exp_exc [$];
    logic [4:0]    exp_cpl [$];
    int            credits;
    int            completed;
    int            committed;
    int            cycles;
    logic [31:0]   lcg_state;
    logic [4:0]    rob_ctr;

    mem_system UUT (.*);

    bind mem_system mem_properties u_props (
        .cpu_clk_i     (cpu_clk_i),
        .rst_n_i       (rst_n_i),
        .commit_i      (commit_i),
        .drain_valid_i (drain_valid),
        .st_valid_i    (st_valid),
        .credit_i      (st_credit),
        .wb_valid_i    (wb_valid_o),
        .wb_rob_i      (wb_rob_o),
        .exc_valid_i   (exc_valid_o),
        .exc_i         (exc_o)
    );

    always #50 cpu_clk_i = ~cpu_clk_i;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};  // better bits low
    endfunction

    // byte as a load sees it: memory, then older stores in program order
    function automatic logic [7:0] model_byte(input logic [31:0] a);
        logic [7:0] v;
        v = ref_mem[a % MEM_BYTES];
        foreach (pend_st[i])
            if (a >= pend_st[i].addr && a < pend_st[i].addr + (32'd1 << pend_st[i].size))
                v = pend_st[i].data[8*(a - pend_st[i].addr) +: 8];
        return v;
    endfunction

    function automatic logic [31:0] model_load(input logic [31:0] a,
                                               input mem_pkg::ls_type_e t);
        logic [31:0] raw;
        raw = '0;
        for (int i = 0; i < (1 << t[1:0]); i++)
            raw[8*i +: 8] = model_byte(a + i);
        case (t)
            mem_pkg::LS_B: return {{24{raw[7]}}, raw[7:0]};
            mem_pkg::LS_H: return {{16{raw[15]}}, raw[15:0]};
            default:       return raw;  // upper bytes already zero
        endcase
    endfunction

    task fail_stop(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_wb(input mem_pkg::wb_t exp, input logic [4:0] exp_rob,
                            input mem_pkg::wb_t got, input logic [4:0] got_rob);
        if (got !== exp)
            fail_stop($sformatf("Fail t=%0t wb_o expected %h got %h", $time, exp, got));
        if (got_rob !== exp_rob)
            fail_stop($sformatf("Fail t=%0t wb_rob_o expected %h got %h",
                                $time, exp_rob, got_rob));
    endtask

    task automatic check_exc(input mem_pkg::exc_t exp, input mem_pkg::exc_t got);
        if (got !== exp)
            fail_stop($sformatf("Fail t=%0t exc_o expected %h got %h", $time, exp, got));
    endtask

    task automatic check_complete(input logic [4:0] exp, input logic [4:0] got);
        if (got !== exp)
            fail_stop($sformatf("Fail t=%0t complete_rob_o expected %h got %h",
                                $time, exp, got));
    endtask

    // outputs settle by mid-cycle
    always @(negedge cpu_clk_i) begin
        exp_ld_t ld_e;
        if (rst_n_i) begin
            cycles++;
            if (cycles > CYCLE_LIMIT)
                fail_stop("timeout, run went past its cycle limit");
            if (op_credit_o) begin
                credits++;
                if (credits > `MEM_IQ_DEPTH)
                    fail_stop("dispatch credit returned with no op in the queue");
            end
            if (complete_o) begin
                if (exp_cpl.size() == 0)
                    fail_stop("store completion with no store outstanding");
                check_complete(exp_cpl.pop_front(), complete_rob_o);
                completed++;
            end
            if (wb_valid_o) begin
                if (exp_wb.size() == 0)
                    fail_stop("writeback with no load outstanding");
                ld_e = exp_wb.pop_front();
                check_wb(ld_e.wb, ld_e.rob, wb_o, wb_rob_o);
            end
            if (exc_valid_o) begin
                if (exp_exc.size() == 0)
                    fail_stop("exception with no misaligned op outstanding");
                check_exc(exp_exc.pop_front(), exc_o);
            end
        end
    end

    task automatic tick(input logic v, input mem_pkg::mem_op_t op, input logic c);
        pend_st_t p;
        @(posedge cpu_clk_i);
        #5;
        op_valid_i = v;
        op_i       = op;
        commit_i   = c;
        if (v)
            credits--;
        if (c) begin
            p = pend_st.pop_front();  // oldest store reaches memory order
            for (int i = 0; i < (1 << p.size); i++)
                ref_mem[(p.addr + i) % MEM_BYTES] = p.data[8*i +: 8];
            committed++;
        end
    endtask

    task automatic idle();
        tick(1'b0, '0, 1'b0);
    endtask

    task automatic dispatch(input logic is_store, input mem_pkg::ls_type_e t,
                            input logic [31:0] base, input logic [31:0] imm,
                            input logic [31:0] data, input logic may_commit);
        mem_pkg::mem_op_t op;
        mem_pkg::exc_t    x;
        pend_st_t         p;
        exp_ld_t          e;
        logic [31:0]      a;
        logic             mis;
        while (credits == 0) begin
            if (may_commit && completed > committed)
                tick(1'b0, '0, 1'b1);
            else
                idle();
        end
        a   = base + imm;
        mis = (t[1:0] == 2'd1 && a[0]) || (t[1:0] == 2'd2 && a[1:0] != 2'b00);
        op.is_store = is_store;
        op.ls_type  = t;
        op.base     = base;
        op.imm      = imm;
        op.data     = data;
        op.rob      = rob_ctr;
        op.dest     = 6'(lcg_next());
        if (mis) begin
            x.rob  = rob_ctr;
            x.code = is_store ? mem_pkg::EXC_ST_MISALIGN : mem_pkg::EXC_LD_MISALIGN;
            x.addr = a;
            exp_exc.push_back(x);
        end else if (is_store) begin
            p.addr = a;
            p.data = data;
            p.size = t[1:0];
            pend_st.push_back(p);
            exp_cpl.push_back(rob_ctr);
        end else begin
            e.wb.dest = op.dest;
            e.wb.data = model_load(a, t);
            e.rob     = rob_ctr;
            exp_wb.push_back(e);
        end
        tick(1'b1, op, 1'b0);
        rob_ctr++;
    endtask

    // commit everything and wait for all responses
    task automatic settle();
        while (exp_wb.size() + exp_exc.size() + exp_cpl.size() != 0 ||
               pend_st.size() != 0) begin
            if (completed > committed)
                tick(1'b0, '0, 1'b1);
            else
                idle();
        end
        repeat (2) idle();
        if (credits != `MEM_IQ_DEPTH)
            fail_stop("dispatch credits were not all returned");
        if (!stb_empty_o)
            fail_stop("store buffer not empty after all stores committed");
    endtask

    task automatic fill_memory();
        for (int i = 0; i < INIT_WORDS; i++)  // hash of the word index
            dispatch(1'b1, mem_pkg::LS_W, 32'(4 * i), 32'h0,
                     32'(i) * 32'h9E37_79B9 + 32'h8080_8080, 1'b1);
        settle();
    endtask

    task automatic store_then_load();
        dispatch(1'b1, mem_pkg::LS_W, 32'h10, 32'h4, lcg_next(), 1'b1);
        settle();
        dispatch(1'b0, mem_pkg::LS_W, 32'h14, 32'h0, '0, 1'b1);
        settle();
    endtask

    task automatic forward_bytes();
        dispatch(1'b1, mem_pkg::LS_B, 32'h0C, 32'h2, 32'h0000_00A7, 1'b0);
        dispatch(1'b0, mem_pkg::LS_W, 32'h0C, 32'h0, '0, 1'b0);
        dispatch(1'b1, mem_pkg::LS_B, 32'h20, 32'h1, 32'h0000_0011, 1'b0);
        dispatch(1'b1, mem_pkg::LS_B, 32'h21, 32'h0, 32'h0000_0022, 1'b0);
        dispatch(1'b0, mem_pkg::LS_BU, 32'h20, 32'h1, '0, 1'b0);
        dispatch(1'b0, mem_pkg::LS_W, 32'h20, 32'h0, '0, 1'b0);
        settle();
    endtask

    task automatic extend_loads();
        dispatch(1'b1, mem_pkg::LS_W, 32'h18, 32'h0, 32'h8FF0_7E81, 1'b1);
        settle();
        dispatch(1'b0, mem_pkg::LS_B, 32'h18, 32'h0, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_BU, 32'h18, 32'h0, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_B, 32'h18, 32'h1, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_H, 32'h18, 32'h0, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_H, 32'h18, 32'h2, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_HU, 32'h18, 32'h2, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_BU, 32'h1B, 32'h0, '0, 1'b1);
        settle();
    endtask

    task automatic misaligned_ops();
        dispatch(1'b0, mem_pkg::LS_H, 32'h20, 32'h1, '0, 1'b1);
        dispatch(1'b0, mem_pkg::LS_W, 32'h20, 32'h2, '0, 1'b1);
        dispatch(1'b1, mem_pkg::LS_W, 32'h24, 32'h3, 32'hDEAD_BEEF, 1'b1);
        settle();
    endtask

    task automatic stall_on_full_buffer();
        int cpl_start;
        cpl_start = completed;
        for (int i = 0; i < `MEM_STB_ENTRIES + 2; i++)
            dispatch(1'b1, mem_pkg::LS_W, 32'h20, 32'(4 * i), lcg_next(), 1'b0);
        dispatch(1'b0, mem_pkg::LS_W, 32'h20, 32'h0, '0, 1'b0);
        dispatch(1'b0, mem_pkg::LS_W, 32'h20, 32'(4 * (`MEM_STB_ENTRIES + 1)), '0, 1'b0);
        repeat (10) idle();
        if (completed - cpl_start != `MEM_STB_ENTRIES)
            fail_stop("store completions did not stop at the store buffer size");
        settle();
    endtask

    task automatic random_mix();
        logic [31:0]        r;
        logic [31:0]        a;
        logic [31:0]        imm;
        logic               is_st;
        mem_pkg::ls_type_e  t;
        for (int n = 0; n < N_RANDOM; n++) begin
            r = lcg_next();
            if (r[0] && completed > committed)
                tick(1'b0, '0, 1'b1);
            r     = lcg_next();
            is_st = (r[3:0] < 4'd6);
            case (int'(r[6:4]) % 5)
                0:       t = mem_pkg::LS_B;
                1:       t = mem_pkg::LS_H;
                2:       t = mem_pkg::LS_W;
                3:       t = mem_pkg::LS_BU;
                default: t = mem_pkg::LS_HU;
            endcase
            if (is_st && t == mem_pkg::LS_BU)
                t = mem_pkg::LS_B;
            if (is_st && t == mem_pkg::LS_HU)
                t = mem_pkg::LS_H;
            a = {26'h0, r[13:8]};
            if (r[15:14] != 2'b00)  // mostly aligned
                a = a & ~((32'd1 << t[1:0]) - 32'd1);
            imm = {{28{r[19]}}, r[19:16]};
            dispatch(is_st, t, a - imm, imm, lcg_next(), 1'b1);
        end
        settle();
    endtask

    initial begin
        cpu_clk_i  = 1'b0;
        rst_n_i    = 1'b0;
        op_valid_i = 1'b0;
        op_i       = '0;
        commit_i   = 1'b0;
        credits    = `MEM_IQ_DEPTH;
        completed  = 0;
        committed  = 0;
        cycles     = 0;
        lcg_state  = 32'd85;
        rob_ctr    = '0;
        repeat (4) @(posedge cpu_clk_i);
        #5;
        rst_n_i = 1'b1;
        if (op_credit_o || complete_o || wb_valid_o || exc_valid_o || !stb_empty_o)
            fail_stop("outputs not idle after reset");
        fill_memory();
        store_then_load();
        forward_bytes();
        extend_loads();
        misaligned_ops();
        stall_on_full_buffer();
        random_mix();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/credit_fifo.sv
hdl/agu.sv
hdl/stb_entry.sv
hdl/store_buffer.sv
hdl/load_unit.sv
hdl/data_mem.sv
hdl/mem_system.sv
tb/mem_properties.sv
tb/tb_mem_system.sv

// File: run.sh
#!/bin/sh
# build and run the load/store testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module tb_mem_system \
    -Mdir obj_dir -o sim_tb_mem_system
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_mem_system > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
